// File: build.f
rtl/risky_pkg.sv
rtl/risky_decode.sv
rtl/risky_operand.sv
rtl/risky_execute.sv
rtl/risky_core.sv
tb/risky_checker.sv
tb/risky_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the core testbench with Verilator, run from the project root

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module risky_tb -o risky_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/risky_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

// File: tb/risky_tb.sv
// Core testbench: instruction encoders, stimulus table, random pass, checks, timeout and verdict
`default_nettype none

module risky_tb import risky_pkg::*; ();

    logic      clk = 1'b0;
    logic      rst_n;
    logic      instr_valid;
    word_t     instr;
    word_t     instr_pc;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      redirect_valid;
    word_t     redirect_pc;

    // Stimulus table, one entry per instruction
    string     names [$];
    word_t     words [$];
    word_t     pcs [$];
    bit        exp_wb [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    bit        exp_redir [$];
    word_t     exp_target [$];

    word_t     model [32]; // Register model for the random pass
    int        seed = 32'hbc1cdf0c;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    int        limit = 0;

    risky_core #(
        .enable_mul(1'b1)
    ) UUT (
        .clk, .rst_n, .instr_valid, .instr, .instr_pc,
        .wb_valid, .wb_rd, .wb_data, .redirect_valid, .redirect_pc
    );

    bind risky_core risky_checker u_checker (
        .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic word_t r_type(funct7_t f7, int rs2, int rs1, funct3_t f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_alu_reg};
    endfunction

    function automatic word_t i_type(int imm, int rs1, funct3_t f3, int rd, opcode_t op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, int rd, opcode_t op);
        return {imm, rd[4:0], op};
    endfunction

    function automatic word_t branch_word(int off, int rs2, int rs1, funct3_t f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t jal_word(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
    endfunction

    task automatic add_test(string name, word_t word, int pc, int wb, int rd, int data,
                            int redir, int target);
        names.push_back(name);
        words.push_back(word);
        pcs.push_back(pc);
        exp_wb.push_back(wb != 0);
        exp_rd.push_back(rd[4:0]);
        exp_data.push_back(data);
        exp_redir.push_back(redir != 0);
        exp_target.push_back(target);
    endtask

    task automatic load_table();
        // name, instruction, pc, wb, rd, data, redirect, target
        add_test("addi x1", i_type(5, 0, f3_add, 1, op_alu_imm), 'h100, 1, 1, 'h5, 0, 0);
        add_test("addi x2", i_type(-3, 0, f3_add, 2, op_alu_imm), 'h104, 1, 2, 'hfffffffd, 0, 0);
        add_test("lui x3", u_type(20'h12345, 3, op_lui), 'h108, 1, 3, 'h12345000, 0, 0);
        add_test("auipc x4", u_type(20'h00001, 4, op_auipc), 'h10c, 1, 4, 'h0000110c, 0, 0);
        add_test("add x5", r_type(f7_base, 2, 1, f3_add, 5), 'h110, 1, 5, 'h2, 0, 0);
        add_test("sub x6", r_type(f7_alt, 1, 5, f3_add, 6), 'h114, 1, 6, 'hfffffffd, 0, 0);
        add_test("sll x7", r_type(f7_base, 5, 6, f3_sll, 7), 'h118, 1, 7, 'hfffffff4, 0, 0);
        add_test("sra x8", r_type(f7_alt, 5, 7, f3_sr, 8), 'h11c, 1, 8, 'hfffffffd, 0, 0);
        add_test("sltu x9", r_type(f7_base, 8, 1, f3_sltu, 9), 'h120, 1, 9, 'h1, 0, 0);
        add_test("and x10", r_type(f7_base, 8, 3, f3_and, 10), 'h124, 1, 10, 'h12345000, 0, 0);
        add_test("srai x11", i_type('h403, 7, f3_sr, 11, op_alu_imm), 'h128, 1, 11, 'hfffffffe,
                 0, 0);
        add_test("mul x12", r_type(f7_mul, 2, 2, f3_mul, 12), 'h12c, 1, 12, 'h9, 0, 0);
        add_test("mulh x13", r_type(f7_mul, 3, 2, f3_mulh, 13), 'h130, 1, 13, 'hffffffff, 0, 0);
        add_test("mulhsu x14", r_type(f7_mul, 2, 3, f3_mulhsu, 14), 'h134, 1, 14, 'h12344fff,
                 0, 0);
        add_test("mulhu x15", r_type(f7_mul, 2, 2, f3_mulhu, 15), 'h138, 1, 15, 'hfffffffa, 0, 0);
        add_test("jal x16", jal_word('h20, 16), 'h13c, 1, 16, 'h140, 1, 'h15c);
        add_test("jalr x17", i_type('h100, 1, 3'b000, 17, op_jalr), 'h15c, 1, 17, 'h160, 1, 'h104);
        add_test("beq taken", branch_word(8, 1, 1, f3_beq), 'h200, 0, 0, 0, 1, 'h208);
        add_test("beq not taken", branch_word(8, 1, 2, f3_beq), 'h204, 0, 0, 0, 0, 0);
        add_test("bne taken", branch_word(-4, 1, 2, f3_bne), 'h208, 0, 0, 0, 1, 'h204);
        add_test("bne not taken", branch_word(8, 1, 1, f3_bne), 'h20c, 0, 0, 0, 0, 0);
        add_test("blt taken", branch_word(16, 1, 2, f3_blt), 'h210, 0, 0, 0, 1, 'h220);
        add_test("blt not taken", branch_word(16, 2, 1, f3_blt), 'h214, 0, 0, 0, 0, 0);
        add_test("bge taken", branch_word(12, 2, 1, f3_bge), 'h218, 0, 0, 0, 1, 'h224);
        add_test("bge not taken", branch_word(12, 1, 2, f3_bge), 'h21c, 0, 0, 0, 0, 0);
        add_test("bltu taken", branch_word('h40, 2, 1, f3_bltu), 'h220, 0, 0, 0, 1, 'h260);
        add_test("bltu not taken", branch_word('h40, 1, 2, f3_bltu), 'h224, 0, 0, 0, 0, 0);
        add_test("bgeu taken", branch_word(-32, 1, 2, f3_bgeu), 'h228, 0, 0, 0, 1, 'h208);
        add_test("bgeu not taken", branch_word(-32, 2, 1, f3_bgeu), 'h22c, 0, 0, 0, 0, 0);
        add_test("addi x0", i_type(1, 1, f3_add, 0, op_alu_imm), 'h230, 0, 0, 0, 0, 0);
        add_test("load opcode", 'h0000a083, 'h234, 0, 0, 0, 0, 0); // Not decoded by this core
    endtask

    // LUI plus ADDI, upper part rounded for the sign-extended low part
    task automatic load_constant(int rd, word_t value, int pc);
        logic [19:0] hi;
        hi = value[31:12] + {19'd0, value[11]};
        model[rd] = {hi, 12'd0};
        add_test("rnd lui", u_type(hi, rd, op_lui), pc, 1, rd, model[rd], 0, 0);
        model[rd] = model[rd] + {{20{value[11]}}, value[11:0]};
        add_test("rnd addi", i_type(value, rd, f3_add, rd, op_alu_imm), pc + 4, 1, rd, model[rd],
                 0, 0);
    endtask

    task automatic add_random_round(int pc);
        word_t a;
        word_t b;
        a = $random(seed);
        b = $random(seed);
        load_constant(5, a, pc);
        load_constant(6, b, pc + 8);
        model[7] = model[5] + model[6];
        add_test("rnd add", r_type(f7_base, 6, 5, f3_add, 7), pc + 16, 1, 7, model[7], 0, 0);
        model[8] = model[5] ^ model[6];
        add_test("rnd xor", r_type(f7_base, 6, 5, f3_xor, 8), pc + 20, 1, 8, model[8], 0, 0);
        model[9] = {31'd0, $signed(model[5]) < $signed(model[6])};
        add_test("rnd slt", r_type(f7_base, 6, 5, f3_slt, 9), pc + 24, 1, 9, model[9], 0, 0);
    endtask

    task automatic check_idle(string when);
        checks++;
        if (wb_valid !== 1'b0 || redirect_valid !== 1'b0) begin
            $display("A strobe was high %s (wb_valid %b, redirect_valid %b)", when, wb_valid,
                     redirect_valid);
            errors++;
        end
    endtask

    task automatic check_entry(int i);
        checks++;
        if (wb_valid !== exp_wb[i]) begin
            $display("%s: write-back strobe %s", names[i], exp_wb[i] ? "missing" : "unexpected");
            errors++;
        end else if (exp_wb[i] && (wb_rd !== exp_rd[i] || wb_data !== exp_data[i])) begin
            $display("** Error %s: expected x%0d = %h, actual x%0d = %h", names[i], exp_rd[i],
                     exp_data[i], wb_rd, wb_data);
            errors++;
        end
        if (redirect_valid !== exp_redir[i]) begin
            $display("%s: redirect strobe %s", names[i], exp_redir[i] ? "missing" : "unexpected");
            errors++;
        end else if (exp_redir[i] && redirect_pc !== exp_target[i]) begin
            $display("** Error %s: expected redirect to %h, actual %h", names[i], exp_target[i],
                     redirect_pc);
            errors++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        load_table();
        for (int k = 0; k < 4; k++) begin
            add_random_round('h300 + 28 * k);
        end
        limit = 10 + names.size() + 20;
        repeat (10) begin
            @(posedge clk);
            #1;
            check_idle("during reset");
        end
        rst_n = 1'b1;
        // Issue back to back, results come out three edges later
        for (int n = 0; n < names.size() + 3; n++) begin
            if (n >= 3) begin
                check_entry(n - 3);
            end else begin
                check_idle("before the first result");
            end
            if (n < names.size()) begin
                instr_valid = 1'b1;
                instr       = words[n];
                instr_pc    = pcs[n];
            end else begin
                instr_valid = 1'b0;
                instr       = '0;
                instr_pc    = '0;
            end
            @(posedge clk);
            #1;
        end
        check_idle("after the last result");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/risky_checker.sv
// Bound assertions on the core's write-back and redirect outputs
`default_nettype none

module risky_checker import risky_pkg::*; (
    input wire logic      clk,
    input wire logic      rst_n,
    input wire logic      wb_valid,
    input wire reg_addr_t wb_rd,
    input wire logic      redirect_valid,
    input wire word_t     redirect_pc
);

    // Strobes cleared by every reset edge
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !wb_valid && !redirect_valid)
        else $error("Strobe high after a reset edge");

    // x0 writes never reach the port
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
                                    wb_valid |-> wb_rd != '0)
        else $error("Write-back to x0 reported");

    a_even_target: assert property (@(posedge clk) disable iff (!rst_n)
                                    redirect_valid |-> !redirect_pc[0])
        else $error("Redirect target %h has bit 0 set", redirect_pc); // JALR clears it

endmodule

`default_nettype wire

// File: rtl/risky_core.sv
// Core top level: decode, operand and execute stages
`default_nettype none

module risky_core import risky_pkg::*; #(
    parameter bit enable_mul = 1'b1
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  instr_valid,
    input  wire word_t instr,
    input  wire word_t instr_pc,
    output logic       wb_valid,
    output reg_addr_t  wb_rd,
    output word_t      wb_data,
    output logic       redirect_valid,
    output word_t      redirect_pc
);

    logic        d_valid;
    inst_class_t d_class;
    reg_addr_t   d_rd;
    reg_addr_t   d_rs1;
    reg_addr_t   d_rs2;
    funct3_t     d_funct3;
    funct7_t     d_funct7;
    word_t       d_imm;
    word_t       d_pc;

    logic        o_valid;
    inst_class_t o_class;
    reg_addr_t   o_rd;
    funct3_t     o_funct3;
    funct7_t     o_funct7;
    word_t       o_rs1_val;
    word_t       o_rs2_val;
    word_t       o_imm;
    word_t       o_pc;

    logic        x_fwd_valid;
    reg_addr_t   x_fwd_rd;
    word_t       x_fwd_data;

    risky_decode u_decode (
        .clk, .rst_n, .instr_valid, .instr, .instr_pc,
        .d_class, .d_valid, .d_rd, .d_rs1, .d_rs2,
        .d_funct3, .d_funct7, .d_imm, .d_pc
    );

    risky_operand u_operand (
        .clk, .rst_n,
        .d_valid, .d_class, .d_rd, .d_rs1, .d_rs2,
        .d_funct3, .d_funct7, .d_imm, .d_pc,
        .x_fwd_valid, .x_fwd_rd, .x_fwd_data,
        .wb_valid, .wb_rd, .wb_data,
        .o_valid, .o_class, .o_rd, .o_funct3, .o_funct7,
        .o_rs1_val, .o_rs2_val, .o_imm, .o_pc
    );

    risky_execute #(
        .enable_mul(enable_mul)
    ) u_execute (
        .clk, .rst_n,
        .o_valid, .o_class, .o_rd, .o_funct3, .o_funct7,
        .o_rs1_val, .o_rs2_val, .o_imm, .o_pc,
        .x_fwd_valid, .x_fwd_rd, .x_fwd_data,
        .wb_valid, .wb_rd, .wb_data,
        .redirect_valid, .redirect_pc
    );

endmodule

`default_nettype wire

// File: rtl/risky_execute.sv
// Execute stage with ALU, multiplier, branch compare, target adders and write-back registers
`default_nettype none

module risky_execute import risky_pkg::*; #(
    parameter bit enable_mul = 1'b1
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        o_valid,
    input  wire inst_class_t o_class,
    input  wire reg_addr_t   o_rd,
    input  wire funct3_t     o_funct3,
    input  wire funct7_t     o_funct7,
    input  wire word_t       o_rs1_val,
    input  wire word_t       o_rs2_val,
    input  wire word_t       o_imm,
    input  wire word_t       o_pc,
    output logic             x_fwd_valid,
    output reg_addr_t        x_fwd_rd,
    output word_t            x_fwd_data,
    output logic             wb_valid,
    output reg_addr_t        wb_rd,
    output word_t            wb_data,
    output logic             redirect_valid,
    output word_t            redirect_pc
);

    word_t              alu_b;
    word_t              alu_res;
    logic               alu_ok;
    logic               mul_sel;
    logic               mul_a_sign;
    logic               mul_b_sign;
    logic signed [65:0] product;
    logic               br_taken;
    word_t              result;
    logic               wr_en;
    logic               take;
    word_t              target;

    assign alu_b = (o_class == class_alu_imm) ? o_imm : o_rs2_val;

    // One 33x33 signed multiplier covers all four variants
    assign mul_sel    = enable_mul && o_class == class_alu_reg && o_funct7 == f7_mul;
    assign mul_a_sign = o_rs1_val[31] && (o_funct3 == f3_mulh || o_funct3 == f3_mulhsu);
    assign mul_b_sign = o_rs2_val[31] && (o_funct3 == f3_mulh);
    assign product    = $signed({{33{mul_a_sign}}, mul_a_sign, o_rs1_val}) *
                        $signed({{33{mul_b_sign}}, mul_b_sign, o_rs2_val});

    always_comb begin
        alu_res = '0;
        alu_ok  = 1'b1;
        if (mul_sel) begin
            alu_ok  = o_funct3 inside {f3_mul, f3_mulh, f3_mulhsu, f3_mulhu}; // No divide
            alu_res = (o_funct3 == f3_mul) ? product[31:0] : product[63:32];
        end else begin
            case ({o_funct7, o_funct3})
                {f7_base, f3_add}:  alu_res = o_rs1_val + alu_b;
                {f7_alt, f3_add}:   alu_res = o_rs1_val - alu_b;
                {f7_base, f3_sll}:  alu_res = o_rs1_val << alu_b[4:0];
                {f7_base, f3_slt}:  alu_res = {31'd0, $signed(o_rs1_val) < $signed(alu_b)};
                {f7_base, f3_sltu}: alu_res = {31'd0, o_rs1_val < alu_b};
                {f7_base, f3_xor}:  alu_res = o_rs1_val ^ alu_b;
                {f7_base, f3_sr}:   alu_res = o_rs1_val >> alu_b[4:0];
                {f7_alt, f3_sr}:    alu_res = $signed(o_rs1_val) >>> alu_b[4:0];
                {f7_base, f3_or}:   alu_res = o_rs1_val | alu_b;
                {f7_base, f3_and}:  alu_res = o_rs1_val & alu_b;
                default:            alu_ok  = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (o_funct3)
            f3_beq:  br_taken = o_rs1_val == o_rs2_val;
            f3_bne:  br_taken = o_rs1_val != o_rs2_val;
            f3_blt:  br_taken = $signed(o_rs1_val) < $signed(o_rs2_val);
            f3_bge:  br_taken = $signed(o_rs1_val) >= $signed(o_rs2_val);
            f3_bltu: br_taken = o_rs1_val < o_rs2_val;
            f3_bgeu: br_taken = o_rs1_val >= o_rs2_val;
            default: br_taken = 1'b0; // Codes 2 and 3 never branch
        endcase
    end

    always_comb begin
        result = o_pc + 32'd4; // Link value
        wr_en  = 1'b0;
        take   = 1'b0;
        target = o_pc + o_imm;
        case (o_class)
            class_lui: begin
                result = o_imm;
                wr_en  = 1'b1;
            end
            class_auipc: begin
                result = target;
                wr_en  = 1'b1;
            end
            class_jal: begin
                wr_en = 1'b1;
                take  = 1'b1;
            end
            class_jalr: begin
                wr_en  = 1'b1;
                take   = 1'b1;
                target = o_rs1_val + o_imm;
                target[0] = 1'b0;
            end
            class_branch:  take = br_taken;
            class_alu_reg,
            class_alu_imm: begin
                result = alu_res;
                wr_en  = alu_ok;
            end
            default: ;
        endcase
    end

    // Bypass carries the value that lands in wb_data
    assign x_fwd_valid = o_valid && wr_en && o_rd != '0;
    assign x_fwd_rd    = o_rd;
    assign x_fwd_data  = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= x_fwd_valid;
            redirect_valid <= o_valid && take;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= o_rd;
        wb_data     <= result;
        redirect_pc <= target;
    end

endmodule

`default_nettype wire

// File: rtl/risky_operand.sv
// Operand stage: register file, read bypass and operand registers
`default_nettype none

module risky_operand import risky_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        d_valid,
    input  wire inst_class_t d_class,
    input  wire reg_addr_t   d_rd,
    input  wire reg_addr_t   d_rs1,
    input  wire reg_addr_t   d_rs2,
    input  wire funct3_t     d_funct3,
    input  wire funct7_t     d_funct7,
    input  wire word_t       d_imm,
    input  wire word_t       d_pc,
    input  wire logic        x_fwd_valid,
    input  wire reg_addr_t   x_fwd_rd,
    input  wire word_t       x_fwd_data,
    input  wire logic        wb_valid,
    input  wire reg_addr_t   wb_rd,
    input  wire word_t       wb_data,
    output logic             o_valid,
    output inst_class_t      o_class,
    output reg_addr_t        o_rd,
    output funct3_t          o_funct3,
    output funct7_t          o_funct7,
    output word_t            o_rs1_val,
    output word_t            o_rs2_val,
    output word_t            o_imm,
    output word_t            o_pc
);

    word_t regs [32];
    word_t rs1_val;
    word_t rs2_val;

    // Write-back port, x0 never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Youngest result wins
    assign rs1_val = (x_fwd_valid && x_fwd_rd == d_rs1) ? x_fwd_data :
                     (wb_valid && wb_rd == d_rs1)       ? wb_data    : regs[d_rs1];
    assign rs2_val = (x_fwd_valid && x_fwd_rd == d_rs2) ? x_fwd_data :
                     (wb_valid && wb_rd == d_rs2)       ? wb_data    : regs[d_rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
            o_class <= class_none;
        end else begin
            o_valid <= d_valid;
            o_class <= d_class;
        end
    end

    always_ff @(posedge clk) begin
        o_rd      <= d_rd;
        o_funct3  <= d_funct3;
        o_funct7  <= d_funct7;
        o_rs1_val <= rs1_val;
        o_rs2_val <= rs2_val;
        o_imm     <= d_imm;
        o_pc      <= d_pc;
    end

endmodule

`default_nettype wire

// File: rtl/risky_decode.sv
// Decode stage: opcode classification, immediate build, registered fields
`default_nettype none

module risky_decode import risky_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    instr_valid,
    input  wire word_t   instr,
    input  wire word_t   instr_pc,
    output inst_class_t  d_class,
    output logic         d_valid,
    output reg_addr_t    d_rd,
    output reg_addr_t    d_rs1,
    output reg_addr_t    d_rs2,
    output funct3_t      d_funct3,
    output funct7_t      d_funct7,
    output word_t        d_imm,
    output word_t        d_pc
);

    opcode_t     opcode;
    funct3_t     funct3;
    inst_class_t cls;
    word_t       imm;
    logic        is_shift;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign is_shift = (funct3 == f3_sll) || (funct3 == f3_sr);

    always_comb begin
        case (opcode)
            op_lui:     cls = class_lui;
            op_auipc:   cls = class_auipc;
            op_jal:     cls = class_jal;
            op_jalr:    cls = class_jalr;
            op_branch:  cls = class_branch;
            op_alu_reg: cls = class_alu_reg;
            op_alu_imm: cls = class_alu_imm;
            default:    cls = class_none; // Loads, stores, system and junk
        endcase
    end

    // Sign-extended immediate by format
    always_comb begin
        case (cls)
            class_lui,
            class_auipc:   imm = {instr[31:12], 12'd0};
            class_jal:     imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            class_branch:  imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            class_jalr,
            class_alu_imm: imm = {{20{instr[31]}}, instr[31:20]};
            default:       imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
            d_class <= class_none;
        end else begin
            d_valid <= instr_valid;
            d_class <= cls;
        end
    end

    always_ff @(posedge clk) begin
        d_rd     <= instr[11:7];
        d_rs1    <= instr[19:15];
        d_rs2    <= instr[24:20];
        d_funct3 <= funct3;
        // Upper immediate bits are not a funct7 except on shifts
        d_funct7 <= (cls == class_alu_imm && !is_shift) ? f7_base : instr[31:25];
        d_imm    <= imm;
        d_pc     <= instr_pc;
    end

endmodule

`default_nettype wire

// File: rtl/risky_pkg.sv
// Shared word and field types, opcode and funct codes, instruction class enum
`default_nettype none

package risky_pkg;

    typedef logic [31:0] word_t;     // Data word, pc or immediate
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [6:0]  opcode_t;

    // Decoded instruction classes
    typedef enum logic [2:0] {
        class_none,
        class_lui,
        class_auipc,
        class_jal,
        class_jalr,
        class_branch,
        class_alu_reg,
        class_alu_imm
    } inst_class_t;

    // Major opcodes
    localparam opcode_t op_lui     = 7'b0110111;
    localparam opcode_t op_auipc   = 7'b0010111;
    localparam opcode_t op_jal     = 7'b1101111;
    localparam opcode_t op_jalr    = 7'b1100111;
    localparam opcode_t op_branch  = 7'b1100011;
    localparam opcode_t op_alu_imm = 7'b0010011;
    localparam opcode_t op_alu_reg = 7'b0110011;

    // Branch compare codes
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // ALU operations
    localparam funct3_t f3_add  = 3'b000; // ADD and SUB
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101; // SRL and SRA
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // M extension, multiplies only
    localparam funct3_t f3_mul    = 3'b000;
    localparam funct3_t f3_mulh   = 3'b001;
    localparam funct3_t f3_mulhsu = 3'b010;
    localparam funct3_t f3_mulhu  = 3'b011;

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000; // SUB, SRA
    localparam funct7_t f7_mul  = 7'b0000001;

endpackage

`default_nettype wire
